//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -sv -j 0
TOP       ?= tb_rv_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) --lint-only --timing -sv --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- include/rv_core_config.svh
// rv32i multicycle core configuration
// reset vector, register file depth and bus address width

`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural integer registers
`define RV_REG_COUNT 32

// apb address width
`define RV_ADDR_WIDTH 32

`endif

//--- sim.f
+incdir+include
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/core_ctrl_if.sv
source/control_fsm.sv
source/pc_unit.sv
source/alu.sv
source/datapath.sv
source/rv_core_top.sv
testbench/tb_apb_memory.sv
testbench/tb_rv_core.sv

//--- source/alu.sv
// rv32i alu
// add, subtract, logic, shifts and compares, with a compare flag for branches

`timescale 1ns/10ps

module alu (
    input  rv_ctrl_pkg::alu_fn_t fn,
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    output logic [31:0]          result,
    output logic                 cmp_true
);
    import rv_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (fn)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            default:  result = a + b;
        endcase
    end

    // set-less-than ops report bit 0, everything else reports equality
    always_comb begin
        if (fn == ALU_SLT || fn == ALU_SLTU) begin
            cmp_true = result[0];
        end else begin
            cmp_true = (result == 32'd0);
        end
    end

endmodule

//--- source/control_fsm.sv
// multicycle sequencer for the rv32i core
// steps fetch, decode, execute, memory and writeback and runs the apb handshake

`timescale 1ns/10ps

module control_fsm (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  pready,
    output logic  psel,
    output logic  penable,
    output logic  pwrite,
    core_ctrl_if.ctrl ctrl,
    output logic  pc_write,
    output logic  pc_load_target
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    typedef enum logic [2:0] {
        S_RESET,
        S_FETCH_SETUP,
        S_FETCH_ACCESS,
        S_DECODE,
        S_EXECUTE,
        S_MEM_SETUP,
        S_MEM_ACCESS,
        S_WRITEBACK
    } state_t;

    state_t  state;
    state_t  state_next;
    logic    is_load;
    logic    is_store;
    logic    is_jump;
    logic    mem_phase;
    logic    branch_taken;
    alu_fn_t op_fn;
    alu_fn_t br_fn;

    assign is_load   = (ctrl.opcode == OP_LOAD);
    assign is_store  = (ctrl.opcode == OP_STORE);
    assign is_jump   = (ctrl.opcode == OP_JAL) || (ctrl.opcode == OP_JALR);
    assign mem_phase = (state == S_MEM_SETUP) || (state == S_MEM_ACCESS);

    // odd funct3 is the negated compare
    assign branch_taken = ctrl.cmp_true ^ ctrl.funct3[0];

    // apb outputs follow the state only
    assign ctrl.fetch = (state == S_FETCH_SETUP) || (state == S_FETCH_ACCESS);
    assign psel       = ctrl.fetch || mem_phase;
    assign penable    = (state == S_FETCH_ACCESS) || (state == S_MEM_ACCESS);
    assign pwrite     = mem_phase && is_store;

    // register and immediate alu ops
    always_comb begin
        case (ctrl.funct3)
            F3_ADD_SUB: op_fn = (ctrl.opcode == OP_REG && ctrl.funct7_5) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op_fn = ALU_SLL;
            F3_SLT:     op_fn = ALU_SLT;
            F3_SLTU:    op_fn = ALU_SLTU;
            F3_XOR:     op_fn = ALU_XOR;
            F3_SRL_SRA: op_fn = ctrl.funct7_5 ? ALU_SRA : ALU_SRL;
            F3_OR:      op_fn = ALU_OR;
            default:    op_fn = ALU_AND;
        endcase
    end

    // branch compares use subtract for eq and ne and set-less-than for lt and ge
    always_comb begin
        case (ctrl.funct3)
            F3_BLT, F3_BGE:   br_fn = ALU_SLT;
            F3_BLTU, F3_BGEU: br_fn = ALU_SLTU;
            default:          br_fn = ALU_SUB;
        endcase
    end

    always_comb begin
        state_next          = state;
        ctrl.alu_fn         = ALU_ADD;
        ctrl.opa_sel        = OPA_RS1;
        ctrl.opb_sel        = OPB_IMM;
        ctrl.wb_sel         = is_load ? WB_MEM : (is_jump ? WB_PC4 : WB_ALU);
        ctrl.ir_write       = 1'b0;
        ctrl.mdr_write      = 1'b0;
        ctrl.alu_out_write  = 1'b0;
        ctrl.reg_write      = 1'b0;
        pc_write            = 1'b0;
        pc_load_target      = 1'b0;
        case (state)
            S_RESET:       state_next = S_FETCH_SETUP;
            S_FETCH_SETUP: state_next = S_FETCH_ACCESS;
            S_FETCH_ACCESS: begin
                if (pready) begin
                    ctrl.ir_write = 1'b1;
                    pc_write      = 1'b1;
                    state_next    = S_DECODE;
                end
            end
            S_DECODE:      state_next = S_EXECUTE;
            S_EXECUTE: begin
                state_next = S_FETCH_SETUP;
                case (ctrl.opcode)
                    OP_REG, OP_IMM: begin
                        ctrl.alu_fn        = op_fn;
                        ctrl.opb_sel       = (ctrl.opcode == OP_REG) ? OPB_RS2 : OPB_IMM;
                        ctrl.alu_out_write = 1'b1;
                        state_next         = S_WRITEBACK;
                    end
                    OP_LUI, OP_AUIPC: begin
                        ctrl.opa_sel       = (ctrl.opcode == OP_LUI) ? OPA_ZERO : OPA_PC;
                        ctrl.alu_out_write = 1'b1;
                        state_next         = S_WRITEBACK;
                    end
                    OP_LOAD, OP_STORE: begin
                        // effective address into alu_out
                        ctrl.alu_out_write = 1'b1;
                        state_next         = S_MEM_SETUP;
                    end
                    OP_BRANCH: begin
                        ctrl.alu_fn    = br_fn;
                        ctrl.opb_sel   = OPB_RS2;
                        pc_write       = branch_taken;
                        pc_load_target = 1'b1;
                    end
                    OP_JAL, OP_JALR: begin
                        pc_write       = 1'b1;
                        pc_load_target = 1'b1;
                        state_next     = S_WRITEBACK;
                    end
                    default: ;
                endcase
            end
            S_MEM_SETUP:   state_next = S_MEM_ACCESS;
            S_MEM_ACCESS: begin
                if (pready) begin
                    ctrl.mdr_write = is_load;
                    state_next     = is_load ? S_WRITEBACK : S_FETCH_SETUP;
                end
            end
            S_WRITEBACK: begin
                ctrl.reg_write = 1'b1;
                state_next     = S_FETCH_SETUP;
            end
            default:       state_next = S_FETCH_SETUP;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_RESET;
        end else begin
            state <= state_next;
        end
    end

    // access phase only inside a transfer already selected
    a_penable_needs_psel: assert property (@(posedge clock) disable iff (!rst_n)
        penable |-> (psel && $past(psel)));

    // wait states freeze the access phase
    a_hold_while_waiting: assert property (@(posedge clock) disable iff (!rst_n)
        (penable && !pready) |=> (state == $past(state)));

endmodule

//--- source/core_ctrl_if.sv
// control and status bundle between the sequencer and the data path

`timescale 1ns/10ps

interface core_ctrl_if;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // controls
    alu_fn_t  alu_fn;
    opa_sel_t opa_sel;
    opb_sel_t opb_sel;
    wb_sel_t  wb_sel;
    logic     ir_write;
    logic     mdr_write;
    logic     alu_out_write;
    logic     reg_write;
    logic     fetch;

    // status from the instruction register and alu
    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    logic       cmp_true;

    modport ctrl (
        output alu_fn, opa_sel, opb_sel, wb_sel,
        output ir_write, mdr_write, alu_out_write, reg_write, fetch,
        input  opcode, funct3, funct7_5, cmp_true
    );

    modport dp (
        input  alu_fn, opa_sel, opb_sel, wb_sel,
        input  ir_write, mdr_write, alu_out_write, reg_write, fetch,
        output opcode, funct3, funct7_5, cmp_true
    );

endinterface

//--- source/datapath.sv
// rv32i multicycle data path
// instruction and data registers, register file, immediates, alu and muxes

`timescale 1ns/10ps

`include "rv_core_config.svh"

module datapath (
    input  logic        clock,
    input  logic        rst_n,
    core_ctrl_if.dp     dp,
    input  logic [31:0] pc,
    input  logic [31:0] pc_plus4,
    input  logic [31:0] prdata,
    output logic [31:0] mem_addr,
    output logic [31:0] pwdata,
    output logic [31:0] target
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    inst_t       ir;
    logic [31:0] inst_pc;
    logic [31:0] link_pc;
    logic [31:0] mdr;
    logic [31:0] alu_out_q;
    logic [31:0] rs1_q;
    logic [31:0] rs2_q;
    logic [31:0] rs1_rd;
    logic [31:0] rs2_rd;
    logic [31:0] imm;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] alu_result;
    logic [31:0] wb_data;
    logic [31:0] regs [0:`RV_REG_COUNT-1];

    assign dp.opcode   = ir.r.opcode;
    assign dp.funct3   = ir.r.funct3;
    assign dp.funct7_5 = ir.r.funct7[5];

    // instruction address and link value ride along with the ir
    always_ff @(posedge clock) begin
        if (dp.ir_write) begin
            ir      <= inst_t'(prdata);
            inst_pc <= pc;
            link_pc <= pc_plus4;
        end
        if (dp.mdr_write) begin
            mdr <= prdata;
        end
        if (dp.alu_out_write) begin
            alu_out_q <= alu_result;
        end
        rs1_q <= rs1_rd;
        rs2_q <= rs2_rd;
    end

    // x0 is hardwired to zero in the register file
    assign rs1_rd = (ir.r.rs1 == 5'd0) ? 32'd0 : regs[ir.r.rs1];
    assign rs2_rd = (ir.r.rs2 == 5'd0) ? 32'd0 : regs[ir.r.rs2];

    always_ff @(posedge clock) begin
        if (dp.reg_write && ir.r.rd != 5'd0) begin
            regs[ir.r.rd] <= wb_data;
        end
    end

    always_comb begin
        case (ir.r.opcode)
            OP_STORE:
                imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
            OP_BRANCH:
                imm = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
                       ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {ir.u.imm_31_12, 12'd0};
            OP_JAL:
                imm = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12,
                       ir.j.imm_11, ir.j.imm_10_1, 1'b0};
            default:
                imm = {{20{ir.i.imm[11]}}, ir.i.imm};
        endcase
    end

    // jalr is register relative, branches and jal are pc relative
    assign target = ((ir.r.opcode == OP_JALR) ? rs1_q : inst_pc) + imm;

    always_comb begin
        case (dp.opa_sel)
            OPA_RS1: opa = rs1_q;
            OPA_PC:  opa = inst_pc;
            default: opa = 32'd0;
        endcase
        case (dp.opb_sel)
            OPB_RS2: opb = rs2_q;
            OPB_IMM: opb = imm;
            default: opb = 32'd4;
        endcase
        case (dp.wb_sel)
            WB_MEM:  wb_data = mdr;
            WB_PC4:  wb_data = link_pc;
            default: wb_data = alu_out_q;
        endcase
    end

    alu i_alu (
        .fn       (dp.alu_fn),
        .a        (opa),
        .b        (opb),
        .result   (alu_result),
        .cmp_true (dp.cmp_true)
    );

    assign mem_addr = dp.fetch ? pc : alu_out_q;
    assign pwdata   = rs2_q;

    // the x0 entry of the register file never takes a writeback
    a_x0_never_written: assert property (@(posedge clock) disable iff (!rst_n)
        $stable(regs[0]));

endmodule

//--- source/pc_unit.sv
// program counter register
// steps by four after a fetch or loads a branch or jump target

`timescale 1ns/10ps

`include "rv_core_config.svh"

module pc_unit (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        pc_write,
    input  logic        pc_load_target,
    input  logic [31:0] target,
    output logic [31:0] pc,
    output logic [31:0] pc_plus4
);

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (pc_write) begin
            if (pc_load_target) begin
                // jalr drops bit 0 of the sum
                pc <= {target[31:1], 1'b0};
            end else begin
                pc <= pc_plus4;
            end
        end
    end

    // targets from the data path must keep word alignment
    a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

//--- source/rv_core_top.sv
// rv32i multicycle core with a single apb master port
// shared by instruction fetch and data access

`timescale 1ns/10ps

`include "rv_core_config.svh"

module rv_core_top (
    input  logic                      clock,
    input  logic                      rst_n,
    output logic [`RV_ADDR_WIDTH-1:0] paddr,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output logic [31:0]               pwdata,
    input  logic [31:0]               prdata,
    input  logic                      pready
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] target;
    logic        pc_write;
    logic        pc_load_target;

    core_ctrl_if i_core_ctrl_if ();

    control_fsm i_control_fsm (
        .clock          (clock),
        .rst_n          (rst_n),
        .pready         (pready),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .ctrl           (i_core_ctrl_if.ctrl),
        .pc_write       (pc_write),
        .pc_load_target (pc_load_target)
    );

    pc_unit i_pc_unit (
        .clock          (clock),
        .rst_n          (rst_n),
        .pc_write       (pc_write),
        .pc_load_target (pc_load_target),
        .target         (target),
        .pc             (pc),
        .pc_plus4       (pc_plus4)
    );

    datapath i_datapath (
        .clock    (clock),
        .rst_n    (rst_n),
        .dp       (i_core_ctrl_if.dp),
        .pc       (pc),
        .pc_plus4 (pc_plus4),
        .prdata   (prdata),
        .mem_addr (paddr),
        .pwdata   (pwdata),
        .target   (target)
    );

endmodule

//--- source/rv_ctrl_pkg.sv
// control encodings shared by the sequencer and the data path
// alu operations and the operand and writeback selects

package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_fn_t;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } opa_sel_t;

    typedef enum logic [1:0] {
        OPB_RS2,
        OPB_IMM,
        OPB_FOUR
    } opb_sel_t;

    // value written back to rd
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

endpackage

//--- source/rv_isa_pkg.sv
// rv32i instruction set encodings
// major opcodes, funct3 values and the instruction format union

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3, bit 0 inverts the condition
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_t    opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_t     opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            opcode_t    opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            opcode_t    opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            opcode_t     opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            opcode_t    opcode;
        } j;
    } inst_t;

endpackage

//--- testbench/tb_apb_memory.sv
// apb slave memory for the core testbench
// word array with lfsr driven wait states, inputs change on the falling edge

`timescale 1ns/10ps

module tb_apb_memory (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);

    logic [31:0] mem [0:255];
    logic [31:0] lfsr;
    int          wait_left;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic load_word(input int idx, input logic [31:0] value);
        mem[idx] = value;
    endtask

    initial begin
        lfsr      = 32'h8008_8d9c;
        wait_left = 0;
        prdata    = 32'd0;
        pready    = 1'b0;
    end

    always @(negedge clock) begin
        logic [1:0] pick;
        prdata <= mem[paddr[9:2]];
        if (!rst_n) begin
            pready <= 1'b0;
        end else if (psel && !penable) begin
            // two bits, one lfsr step each
            pick[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            pick[1] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            wait_left = pick;
            pready <= 1'b0;
        end else if (psel && penable && !pready) begin
            if (wait_left == 0) begin
                pready <= 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end else begin
            pready <= 1'b0;
        end
    end

    always @(posedge clock) begin
        if (psel && penable && pready && pwrite) begin
            mem[paddr[9:2]] <= pwdata;
        end
    end

endmodule

//--- testbench/tb_rv_core.sv
// testbench for the rv32i multicycle core
// runs a hand assembled program over apb and checks bus and results with assertions

`timescale 1ns/10ps

`include "rv_core_config.svh"

module tb_rv_core;

    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [31:0] RESULT_BASE = 32'h0000_0200;
    localparam logic [31:0] POISON_ADDR = 32'h0000_02f0;
    localparam logic [31:0] DATA_ADDR   = 32'h0000_0300;

    logic        clock;
    logic        rst_n;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    logic [31:0] exp_val [0:63];
    logic        written [0:63];
    int          n_exp;
    int          prog_pc;
    logic [31:0] halt_addr;
    int          halt_seen;
    int          cycles;
    int          cycle_limit;
    logic        first_setup;

    wire xfer_done = psel && penable && pready;

    rv_core_top i_rv_core_top (
        .clock   (clock),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    tb_apb_memory i_memory (
        .clock   (clock),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    always #50 clock = ~clock;

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        i_memory.load_word(prog_pc / 4, word);
        prog_pc = prog_pc + 4;
    endtask

    // sw rs2 into the next result slot
    task automatic store_result(input logic [4:0] rs2, input logic [31:0] value);
        emit(enc_s(12'(n_exp * 4), rs2, 5'd10));
        exp_val[n_exp] = value;
        n_exp = n_exp + 1;
    endtask

    task automatic skip_poison(input logic [31:0] branch_word);
        emit(branch_word);
        emit(enc_s(12'h0f0, 5'd1, 5'd10));
    endtask

    task automatic build_program();
        logic [31:0] p;
        emit(enc_i(12'd7, 5'd0, 3'b000, 5'd1, OPC_IMM));
        emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, OPC_IMM));
        emit(enc_i(12'h200, 5'd0, 3'b000, 5'd10, OPC_IMM));
        // register ops on x1 = 7 and x2 = -3
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        store_result(5'd3, 32'h0000_0004);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
        store_result(5'd3, 32'h0000_000a);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
        store_result(5'd3, 32'h0000_0005);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3));
        store_result(5'd3, 32'hffff_ffff);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
        store_result(5'd3, 32'hffff_fffa);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd3));
        store_result(5'd3, 32'h0000_0001);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd3));
        store_result(5'd3, 32'h0000_0000);
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd3));
        store_result(5'd3, 32'h0000_0380);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd3));
        store_result(5'd3, 32'h01ff_ffff);
        emit(enc_r(7'h20, 5'd1, 5'd2, 3'b101, 5'd3));
        store_result(5'd3, 32'hffff_ffff);
        // immediate ops
        emit(enc_i(12'h004, 5'd1, 3'b001, 5'd3, OPC_IMM));
        store_result(5'd3, 32'h0000_0070);
        emit(enc_i(12'h01c, 5'd2, 3'b101, 5'd3, OPC_IMM));
        store_result(5'd3, 32'h0000_000f);
        emit(enc_i(12'h401, 5'd2, 3'b101, 5'd3, OPC_IMM));
        store_result(5'd3, 32'hffff_fffe);
        emit(enc_i(12'hffe, 5'd2, 3'b010, 5'd3, OPC_IMM));
        store_result(5'd3, 32'h0000_0001);
        emit(enc_i(12'hfff, 5'd1, 3'b011, 5'd3, OPC_IMM));
        store_result(5'd3, 32'h0000_0001);
        emit(enc_i(12'h0ff, 5'd1, 3'b100, 5'd3, OPC_IMM));
        store_result(5'd3, 32'h0000_00f8);
        emit(enc_i(12'h100, 5'd1, 3'b110, 5'd3, OPC_IMM));
        store_result(5'd3, 32'h0000_0107);
        emit(enc_i(12'h0f0, 5'd2, 3'b111, 5'd3, OPC_IMM));
        store_result(5'd3, 32'h0000_00f0);
        // upper immediates
        emit({20'habcde, 5'd3, OPC_LUI});
        store_result(5'd3, 32'habcd_e000);
        p = prog_pc;
        emit({20'h00001, 5'd3, OPC_AUIPC});
        store_result(5'd3, p + 32'h0000_1000);
        // load plus immediate
        emit(enc_i(12'h100, 5'd10, 3'b010, 5'd5, OPC_LOAD));
        emit(enc_i(12'h011, 5'd5, 3'b000, 5'd6, OPC_IMM));
        store_result(5'd6, 32'h1234_5689);
        // taken branches each jump over a poison store
        skip_poison(enc_b(13'd8, 5'd1, 5'd1, 3'b000));
        skip_poison(enc_b(13'd8, 5'd1, 5'd2, 3'b100));
        skip_poison(enc_b(13'd8, 5'd2, 5'd1, 3'b101));
        skip_poison(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
        // a branch not taken falls through to its store
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b001));
        store_result(5'd1, 32'h0000_0007);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b100));
        store_result(5'd2, 32'hffff_fffd);
        // jal link
        p = prog_pc;
        skip_poison(enc_j(21'd8, 5'd7));
        store_result(5'd7, p + 32'd4);
        // jalr with an odd offset drops bit 0 of the target
        p = prog_pc;
        emit(enc_i(12'(p + 12), 5'd0, 3'b000, 5'd9, OPC_IMM));
        skip_poison(enc_i(12'd1, 5'd9, 3'b000, 5'd8, OPC_JALR));
        store_result(5'd8, p + 32'd8);
        halt_addr = prog_pc;
        emit(enc_j(21'd0, 5'd0));
    endtask

    function automatic logic in_result_area(input logic [31:0] a);
        return (a >= RESULT_BASE) && (a < POISON_ADDR);
    endfunction

    function automatic int slot_of(input logic [31:0] a);
        return int'((a - RESULT_BASE) >> 2);
    endfunction

    task automatic fail_now();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    initial begin
        clock       = 1'b0;
        rst_n       = 1'b0;
        n_exp       = 0;
        prog_pc     = 0;
        halt_seen   = 0;
        cycles      = 0;
        first_setup = 1'b1;
        for (int i = 0; i < 64; i++) begin
            written[i] = 1'b0;
            exp_val[i] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            i_memory.load_word(i, 32'hdead_0000 | (i * 4));
        end
        i_memory.load_word(DATA_ADDR / 4, 32'h1234_5678);
        build_program();
        // two passes of slack over the worst case of forty cycles each
        cycle_limit = 40 * (prog_pc / 4) * 2;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

    always @(posedge clock) begin
        if (rst_n && psel && !penable) begin
            first_setup <= 1'b0;
        end
        if (rst_n && xfer_done && pwrite && in_result_area(paddr)) begin
            written[slot_of(paddr)] <= 1'b1;
        end
    end

    // end of run and timeout
    always @(posedge clock) begin
        int missing;
        missing = 0;
        cycles = cycles + 1;
        if (rst_n && xfer_done && !pwrite && paddr == halt_addr) begin
            halt_seen = halt_seen + 1;
        end
        if (halt_seen == 2) begin
            for (int i = 0; i < n_exp; i++) begin
                if (!written[i]) begin
                    $display("result slot %0d was never stored", i);
                    missing = missing + 1;
                end
            end
            if (missing != 0) begin
                fail_now();
            end else begin
                $display("TEST PASS");
                $finish;
            end
        end else if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles without reaching the halt loop", cycles);
            fail_now();
        end
    end

    a_idle_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> !psel)
        else begin
            $display("psel was high in the first cycle after reset");
            fail_now();
        end

    a_first_fetch_addr: assert property (@(posedge clock) disable iff (!rst_n)
        (psel && !penable && first_setup) |-> (paddr == `RV_RESET_PC))
        else begin
            $display("[ERROR] paddr = %h, expected %h", $sampled(paddr), `RV_RESET_PC);
            fail_now();
        end

    a_setup_then_access: assert property (@(posedge clock) disable iff (!rst_n)
        (psel && !penable) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            $display("setup phase was not followed by a matching access phase");
            fail_now();
        end

    a_stable_in_wait: assert property (@(posedge clock) disable iff (!rst_n)
        (psel && penable && !pready) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            $display("apb address, direction or write data changed during a wait state");
            fail_now();
        end

    a_no_poison_write: assert property (@(posedge clock) disable iff (!rst_n)
        !(psel && pwrite && paddr == POISON_ADDR))
        else begin
            $display("a skipped store reached the poison address");
            fail_now();
        end

    a_result_in_table: assert property (@(posedge clock) disable iff (!rst_n)
        (xfer_done && pwrite && in_result_area(paddr)) |-> (slot_of(paddr) < n_exp))
        else begin
            $display("store to unused result address %h", $sampled(paddr));
            fail_now();
        end

    a_result_value: assert property (@(posedge clock) disable iff (!rst_n)
        (xfer_done && pwrite && in_result_area(paddr)) |->
            (pwdata == exp_val[slot_of(paddr)]))
        else begin
            $display("[ERROR] pwdata = %h, expected %h at paddr %h", $sampled(pwdata),
                     exp_val[slot_of($sampled(paddr))], $sampled(paddr));
            fail_now();
        end

    a_result_once: assert property (@(posedge clock) disable iff (!rst_n)
        (xfer_done && pwrite && in_result_area(paddr)) |-> !written[slot_of(paddr)])
        else begin
            $display("result address %h was written twice", $sampled(paddr));
            fail_now();
        end

endmodule
